//--- Bender.yml
package:
  name: dram_dma

sources:
  - include_dirs:
      - hw
    files:
      - hw/dram_dma_pkg.sv
      - hw/sig_pipe.sv
      - hw/rst_sync_tree.sv
      - hw/mem_scrubber.sv
      - hw/ctl_status.sv
      - hw/dram_dma_top.sv
      - verif/tb_dram_dma.sv

//--- hw/ctl_status.sv
/*
  Control and status
  Captures the control word and hands out the scrub enables, answers a
  function-level reset, and drives the identity words with either the
  fixed IDs or a selected channel's live scrub address
*/

`timescale 1ns/1ps
`include "dram_dma_defs.svh"

module ctl_status
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  dram_dma_pkg::ctl_word_t ctl0,
   input  logic                    flr_assert,
   output logic                    flr_done,
   output logic [`DD_NUM_CHAN-1:0] scrub_en,
   input  logic [`DD_ADDR_W-1:0]   scrub_addr [`DD_NUM_CHAN],
   output logic [31:0]             id0,
   output logic [31:0]             id1
);

   dram_dma_pkg::ctl_word_t ctl_q;
   dram_dma_pkg::dbg_chan_e dbg_sel;
   logic                    flr_assert_q;
   logic [`DD_ADDR_W-1:0]   sel_addr;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ctl_q <= '0;
      else
         ctl_q <= ctl0;
   end

   assign scrub_en = ctl_q.scrub_en;

   // FLR done pulses and toggles while the assert is held
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q & ~flr_done;
      end
   end

   // ------------------------------------------------------------------------
   // Debug view of the scrub addresses
   // ------------------------------------------------------------------------
   assign dbg_sel = dram_dma_pkg::dbg_chan_e'(ctl_q.dbg_sel);

   always_comb
   begin
      case (dbg_sel)
         dram_dma_pkg::DBG_CHAN1: sel_addr = scrub_addr[1];
         dram_dma_pkg::DBG_CHAN2: sel_addr = scrub_addr[2];
         dram_dma_pkg::DBG_CHAN3: sel_addr = scrub_addr[3];
         default:                 sel_addr = scrub_addr[0];
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         id0 <= `DD_CL_ID0;
         id1 <= `DD_CL_ID1;
      end
      else
      begin
         id0 <= ctl_q.dbg_en ? sel_addr[31:0]  : `DD_CL_ID0;
         id1 <= ctl_q.dbg_en ? sel_addr[63:32] : `DD_CL_ID1;
      end
   end

endmodule

//--- hw/dram_dma_defs.svh
/*
  DRAM DMA glue layer parameters
  Stage counts, channel count, address width, scrub range and the fixed
  identity words shared by the RTL and the testbench
*/

`ifndef DRAM_DMA_DEFS_SVH
`define DRAM_DMA_DEFS_SVH

// One scrubber per memory channel
`define DD_NUM_CHAN 4

// Memory address width
`define DD_ADDR_W 64

// Reset pipeline depth ahead of the synchronizer and of each slice
`define DD_RST_STAGES 4

// Statistics request and response pipeline depth for timing closure
`define DD_STAT_STAGES 8

// Last scrubbed byte address of a short 8 KiB range
`define DD_SCRUB_MAX_ADDR 64'h1FFF

// Bytes per burst of 16 beats of 64 bytes
`define DD_SCRUB_BURST_BYTES 1024

// Fixed identity words
`define DD_CL_ID0 32'hF001_1D0F
`define DD_CL_ID1 32'h1D51_FEDC

`endif

//--- hw/dram_dma_pkg.sv
/*
  DRAM DMA glue layer types
  Bundled statistics, control and scrub port structs, plus the scrubber
  state and debug channel select encodings
*/

`include "dram_dma_defs.svh"

package dram_dma_pkg;

   // 42-bit statistics request from the shell
   typedef struct packed {
      logic        wr;
      logic        rd;
      logic [7:0]  addr;
      logic [31:0] wdata;
   } stat_req_t;

   // 41-bit statistics response from the DDR side
   typedef struct packed {
      logic        ack;
      logic [7:0]  int_vec;
      logic [31:0] rdata;
   } stat_rsp_t;

   // Control word with debug fields on top and scrub enables at the bottom
   typedef struct packed {
      logic                       dbg_en;
      logic [2:0]                 dbg_sel;
      logic [27-`DD_NUM_CHAN:0]   rsvd;
      logic [`DD_NUM_CHAN-1:0]    scrub_en;
   } ctl_word_t;

   // One burst request on the scrub port
   typedef struct packed {
      logic                  valid;
      logic [`DD_ADDR_W-1:0] addr;
   } scrub_req_t;

   typedef enum logic [1:0] {
      SCRUB_IDLE = 2'd0,
      SCRUB_RUN  = 2'd1,
      SCRUB_DONE = 2'd2
   } scrub_state_e;

   // Codes 4 to 7 are not named and select channel 0
   typedef enum logic [2:0] {
      DBG_CHAN0 = 3'd0,
      DBG_CHAN1 = 3'd1,
      DBG_CHAN2 = 3'd2,
      DBG_CHAN3 = 3'd3
   } dbg_chan_e;

endpackage

//--- hw/dram_dma_top.sv
/*
  DRAM DMA glue layer top
  Ties together the reset tree, the control and status block, one
  scrubber per memory channel and the staged statistics bus
*/

`timescale 1ns/1ps
`include "dram_dma_defs.svh"

module dram_dma_top
(
   input  logic                     clk,
   input  logic                     rst_n,

   // Control and identity
   input  dram_dma_pkg::ctl_word_t  ctl0,
   input  logic                     flr_assert,
   output logic                     flr_done,
   output logic [31:0]              id0,
   output logic [31:0]              id1,

   // Scrub ports
   output dram_dma_pkg::scrub_req_t scrub_req [`DD_NUM_CHAN],
   input  logic [`DD_NUM_CHAN-1:0]  scrub_ready,
   output logic [`DD_NUM_CHAN-1:0]  scrub_done,

   // Statistics bus
   input  dram_dma_pkg::stat_req_t  stat_req_in,
   output dram_dma_pkg::stat_req_t  stat_req_out,
   input  dram_dma_pkg::stat_rsp_t  stat_rsp_in,
   output dram_dma_pkg::stat_rsp_t  stat_rsp_out
);

   logic                    sync_rst_n;
   logic                    scrub_rst_n;
   logic                    ctl_rst_n;
   logic [`DD_NUM_CHAN-1:0] scrub_en;
   logic [`DD_ADDR_W-1:0]   scrub_addr [`DD_NUM_CHAN];

   rst_sync_tree u_rst_tree
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .sync_rst_n  (sync_rst_n),
      .scrub_rst_n (scrub_rst_n),
      .ctl_rst_n   (ctl_rst_n)
   );

   ctl_status u_ctl_status
   (
      .clk        (clk),
      .rst_n      (ctl_rst_n),
      .ctl0       (ctl0),
      .flr_assert (flr_assert),
      .flr_done   (flr_done),
      .scrub_en   (scrub_en),
      .scrub_addr (scrub_addr),
      .id0        (id0),
      .id1        (id1)
   );

   // ------------------------------------------------------------------------
   // Scrubbers for channels 0 to 3
   // ------------------------------------------------------------------------
   for (genvar i = 0; i < `DD_NUM_CHAN; i++)
   begin : g_scrub
      mem_scrubber u_scrubber
      (
         .clk         (clk),
         .rst_n       (scrub_rst_n),
         .enable      (scrub_en[i]),
         .scrub_req   (scrub_req[i]),
         .scrub_ready (scrub_ready[i]),
         .scrub_addr  (scrub_addr[i]),
         .scrub_done  (scrub_done[i])
      );
   end

   // ------------------------------------------------------------------------
   // Statistics request and response pipes
   // ------------------------------------------------------------------------
   sig_pipe
   #(
      .WIDTH  ($bits(dram_dma_pkg::stat_req_t)),
      .STAGES (`DD_STAT_STAGES)
   )
   u_stat_req_pipe
   (
      .clk     (clk),
      .rst_n   (sync_rst_n),
      .in_bus  (stat_req_in),
      .out_bus (stat_req_out)
   );

   sig_pipe
   #(
      .WIDTH  ($bits(dram_dma_pkg::stat_rsp_t)),
      .STAGES (`DD_STAT_STAGES)
   )
   u_stat_rsp_pipe
   (
      .clk     (clk),
      .rst_n   (sync_rst_n),
      .in_bus  (stat_rsp_in),
      .out_bus (stat_rsp_out)
   );

endmodule

//--- hw/mem_scrubber.sv
/*
  Memory scrubber, one channel
  Walks the scrub range from address zero in fixed bursts over a
  valid/ready request port and flags completion. Dropping the enable
  returns the channel to idle.
*/

`timescale 1ns/1ps
`include "dram_dma_defs.svh"

module mem_scrubber
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     enable,
   output dram_dma_pkg::scrub_req_t scrub_req,
   input  logic                     scrub_ready,
   output logic [`DD_ADDR_W-1:0]    scrub_addr,
   output logic                     scrub_done
);

   localparam logic [`DD_ADDR_W-1:0] BURST_STEP = `DD_SCRUB_BURST_BYTES;
   localparam logic [`DD_ADDR_W-1:0] MAX_ADDR   = `DD_SCRUB_MAX_ADDR;

   dram_dma_pkg::scrub_state_e state_q;
   dram_dma_pkg::scrub_state_e state_d;
   logic [`DD_ADDR_W-1:0]      addr_q;
   logic [`DD_ADDR_W-1:0]      addr_d;
   logic [`DD_ADDR_W-1:0]      next_addr;

   assign next_addr = addr_q + BURST_STEP;

   // ------------------------------------------------------------------------
   // Next state
   // ------------------------------------------------------------------------
   always_comb
   begin
      state_d = state_q;
      addr_d  = addr_q;
      if (!enable)
      begin
         state_d = dram_dma_pkg::SCRUB_IDLE;
         addr_d  = '0;
      end
      else
      begin
         case (state_q)
            dram_dma_pkg::SCRUB_IDLE:
            begin
               state_d = dram_dma_pkg::SCRUB_RUN;
               addr_d  = '0;
            end
            dram_dma_pkg::SCRUB_RUN:
            begin
               // Advance only on an accepted burst
               if (scrub_ready)
               begin
                  addr_d = next_addr;
                  if (next_addr > MAX_ADDR)
                     state_d = dram_dma_pkg::SCRUB_DONE;
               end
            end
            dram_dma_pkg::SCRUB_DONE:
               state_d = dram_dma_pkg::SCRUB_DONE;
            default:
               state_d = dram_dma_pkg::SCRUB_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= dram_dma_pkg::SCRUB_IDLE;
         addr_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         addr_q  <= addr_d;
      end
   end

   // Request holds while ready is low since both come from registers
   always_comb
   begin
      scrub_req.valid = (state_q == dram_dma_pkg::SCRUB_RUN);
      scrub_req.addr  = addr_q;
   end

   assign scrub_addr = addr_q;
   assign scrub_done = (state_q == dram_dma_pkg::SCRUB_DONE);

endmodule

//--- hw/rst_sync_tree.sv
/*
  Reset synchronizer tree
  Pipelines and synchronizes the raw reset into sync_rst_n, then fans it
  out through per-block slices for the scrubbers and the control block.
  All outputs assert at once and deassert in stages.
*/

`timescale 1ns/1ps
`include "dram_dma_defs.svh"

module rst_sync_tree
(
   input  logic clk,
   input  logic rst_n,
   output logic sync_rst_n,
   output logic scrub_rst_n,
   output logic ctl_rst_n
);

   localparam int NUM_SLICES = 2;

   logic [`DD_RST_STAGES-1:0] pipe_q;
   logic                      pre_sync_q;
   logic [`DD_RST_STAGES-1:0] slice_q [NUM_SLICES];

   // Raw reset pipe followed by the two-flop synchronizer
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pipe_q     <= '0;
         pre_sync_q <= 1'b0;
         sync_rst_n <= 1'b0;
      end
      else
      begin
         pipe_q     <= {pipe_q[`DD_RST_STAGES-2:0], 1'b1};
         pre_sync_q <= pipe_q[`DD_RST_STAGES-1];
         sync_rst_n <= pre_sync_q;
      end
   end

   // ------------------------------------------------------------------------
   // Local reset slices with one chain per block
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int s = 0; s < NUM_SLICES; s++)
            slice_q[s] <= '0;
      end
      else
      begin
         for (int s = 0; s < NUM_SLICES; s++)
            slice_q[s] <= {slice_q[s][`DD_RST_STAGES-2:0], sync_rst_n};
      end
   end

   assign scrub_rst_n = slice_q[0][`DD_RST_STAGES-1];
   assign ctl_rst_n   = slice_q[1][`DD_RST_STAGES-1];

endmodule

//--- hw/sig_pipe.sv
/*
  Signal pipe
  Delays a bundled signal by exactly STAGES clocks, every stage cleared
  by an asynchronous active-low reset
*/

`timescale 1ns/1ps

module sig_pipe
#(
   parameter int WIDTH  = 1,
   parameter int STAGES = 1
)
(
   input  logic             clk,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   logic [WIDTH-1:0] stage_q [STAGES];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
            stage_q[i] <= '0;
      end
      else
      begin
         stage_q[0] <= in_bus;
         for (int i = 1; i < STAGES; i++)
            stage_q[i] <= stage_q[i-1];
      end
   end

   assign out_bus = stage_q[STAGES-1];

endmodule

//--- tb.f
+incdir+hw
hw/dram_dma_pkg.sv
hw/sig_pipe.sv
hw/rst_sync_tree.sv
hw/mem_scrubber.sv
hw/ctl_status.sv
hw/dram_dma_top.sv
verif/tb_dram_dma.sv

//--- verif/tb_dram_dma.sv
/*
  DRAM DMA glue layer testbench
  Drives random statistics traffic, FLR requests, control words and scrub
  back-pressure into the top level. Every output is checked each cycle
  against a reference model kept in this testbench.
*/

`timescale 1ns/1ps
`include "dram_dma_defs.svh"

module tb_dram_dma;

   localparam int          NCH      = `DD_NUM_CHAN;
   localparam logic [63:0] BURST    = `DD_SCRUB_BURST_BYTES;
   localparam logic [63:0] MAX_ADDR = `DD_SCRUB_MAX_ADDR;

   logic                     clk;
   logic                     rst_n;
   dram_dma_pkg::ctl_word_t  ctl0;
   logic                     flr_assert;
   logic                     flr_done;
   logic [31:0]              id0;
   logic [31:0]              id1;
   dram_dma_pkg::scrub_req_t scrub_req [NCH];
   logic [NCH-1:0]           scrub_ready;
   logic [NCH-1:0]           scrub_done;
   dram_dma_pkg::stat_req_t  stat_req_in;
   dram_dma_pkg::stat_req_t  stat_req_out;
   dram_dma_pkg::stat_rsp_t  stat_rsp_in;
   dram_dma_pkg::stat_rsp_t  stat_rsp_out;

   // Reference model state
   dram_dma_pkg::ctl_word_t    ctl_m;
   logic                       flr_q_m;
   logic                       flr_done_m;
   dram_dma_pkg::scrub_state_e st_m [NCH];
   logic [63:0]                addr_m [NCH];
   int                         acc_cnt [NCH];
   logic [31:0]                id0_m;
   logic [31:0]                id1_m;
   dram_dma_pkg::stat_req_t    req_q [$];
   dram_dma_pkg::stat_rsp_t    rsp_q [$];
   int                         due_q [$];

   logic [31:0] rng_state;
   int          cyc;
   int          errors;
   int          tests_run;
   int          tests_failed;
   bit          checking;

   dram_dma_top DUT
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .ctl0         (ctl0),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .id0          (id0),
      .id1          (id1),
      .scrub_req    (scrub_req),
      .scrub_ready  (scrub_ready),
      .scrub_done   (scrub_done),
      .stat_req_in  (stat_req_in),
      .stat_req_out (stat_req_out),
      .stat_rsp_in  (stat_rsp_in),
      .stat_rsp_out (stat_rsp_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Random numbers and compare tasks
   // ------------------------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand32();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   task automatic check_stat_req(input string name, input dram_dma_pkg::stat_req_t got,
                                 input dram_dma_pkg::stat_req_t exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_stat_rsp(input string name, input dram_dma_pkg::stat_rsp_t got,
                                 input dram_dma_pkg::stat_rsp_t exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_scrub(input string name, input dram_dma_pkg::scrub_req_t got,
                              input dram_dma_pkg::scrub_req_t exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_id(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // ------------------------------------------------------------------------
   // Advance the model one clock with the inputs seen at the edge and check
   // ------------------------------------------------------------------------
   task automatic next_cycle();
      dram_dma_pkg::ctl_word_t  ctl_in;
      logic                     flr_in;
      logic [NCH-1:0]           rdy_in;
      dram_dma_pkg::scrub_req_t req_pre [NCH];
      dram_dma_pkg::scrub_req_t exp_req;
      dram_dma_pkg::stat_req_t  exp_sreq;
      dram_dma_pkg::stat_rsp_t  exp_srsp;
      logic [63:0]              sel;
      ctl_in = ctl0;
      flr_in = flr_assert;
      rdy_in = scrub_ready;
      for (int i = 0; i < NCH; i++)
         req_pre[i] = scrub_req[i];
      req_q.push_back(stat_req_in);
      rsp_q.push_back(stat_rsp_in);
      due_q.push_back(cyc + `DD_STAT_STAGES);
      @(posedge clk);
      #1;
      cyc++;
      // Accepted bursts must walk 0x0, 0x400, ... in order
      for (int i = 0; i < NCH; i++)
      begin
         if (checking && req_pre[i].valid && rdy_in[i])
         begin
            exp_req.valid = 1'b1;
            exp_req.addr  = BURST * acc_cnt[i];
            check_scrub($sformatf("accepted scrub_req[%0d]", i), req_pre[i], exp_req);
            acc_cnt[i]++;
         end
      end
      // Identity words come from the old control word and old addresses
      case (ctl_m.dbg_sel)
         3'd1:    sel = addr_m[1];
         3'd2:    sel = addr_m[2];
         3'd3:    sel = addr_m[3];
         default: sel = addr_m[0];
      endcase
      id0_m = ctl_m.dbg_en ? sel[31:0]  : `DD_CL_ID0;
      id1_m = ctl_m.dbg_en ? sel[63:32] : `DD_CL_ID1;
      flr_done_m = flr_q_m & ~flr_done_m;
      flr_q_m    = flr_in;
      for (int i = 0; i < NCH; i++)
      begin
         if (!ctl_m.scrub_en[i])
         begin
            st_m[i]    = dram_dma_pkg::SCRUB_IDLE;
            addr_m[i]  = '0;
            acc_cnt[i] = 0;
         end
         else if (st_m[i] == dram_dma_pkg::SCRUB_IDLE)
            st_m[i] = dram_dma_pkg::SCRUB_RUN;
         else if (st_m[i] == dram_dma_pkg::SCRUB_RUN && rdy_in[i])
         begin
            addr_m[i] = addr_m[i] + BURST;
            if (addr_m[i] > MAX_ADDR)
               st_m[i] = dram_dma_pkg::SCRUB_DONE;
         end
      end
      ctl_m = ctl_in;
      if (due_q.size() > 0 && due_q[0] == cyc)
      begin
         exp_sreq = req_q.pop_front();
         exp_srsp = rsp_q.pop_front();
         void'(due_q.pop_front());
         if (checking)
         begin
            check_stat_req("stat_req_out", stat_req_out, exp_sreq);
            check_stat_rsp("stat_rsp_out", stat_rsp_out, exp_srsp);
         end
      end
      if (checking)
      begin
         check_flag("flr_done", flr_done, flr_done_m);
         check_id("id0", id0, id0_m);
         check_id("id1", id1, id1_m);
         for (int i = 0; i < NCH; i++)
         begin
            exp_req.valid = (st_m[i] == dram_dma_pkg::SCRUB_RUN);
            exp_req.addr  = addr_m[i];
            check_scrub($sformatf("scrub_req[%0d]", i), scrub_req[i], exp_req);
            check_flag($sformatf("scrub_done[%0d]", i), scrub_done[i],
                       st_m[i] == dram_dma_pkg::SCRUB_DONE);
         end
      end
   endtask

   task automatic end_test(input int num, input string name, input int err_before);
      tests_run++;
      if (errors != err_before)
         tests_failed++;
      $display("Test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAILED");
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial
   begin
      int                       n;
      int                       err0;
      logic [31:0]              r;
      dram_dma_pkg::scrub_req_t exp_req;
      rng_state    = 32'hd57f_e030;
      rst_n        = 1'b0;
      ctl0         = '0;
      flr_assert   = 1'b0;
      scrub_ready  = '0;
      stat_req_in  = '0;
      stat_rsp_in  = '0;
      ctl_m        = '0;
      flr_q_m      = 1'b0;
      flr_done_m   = 1'b0;
      cyc          = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      checking     = 1'b0;
      for (int i = 0; i < NCH; i++)
      begin
         st_m[i]    = dram_dma_pkg::SCRUB_IDLE;
         addr_m[i]  = '0;
         acc_cnt[i] = 0;
      end
      repeat (3) next_cycle();
      rst_n = 1'b1;
      // Wait for the block reset slices to release
      n = 0;
      while (!(DUT.scrub_rst_n && DUT.ctl_rst_n) && n < 50)
      begin
         next_cycle();
         n++;
      end
      if (!(DUT.scrub_rst_n && DUT.ctl_rst_n))
      begin
         $display("Timeout: reset slices never released");
         errors++;
      end
      checking = 1'b1;

      err0 = errors;
      check_flag("flr_done", flr_done, 1'b0);
      check_stat_req("stat_req_out", stat_req_out, '0);
      check_stat_rsp("stat_rsp_out", stat_rsp_out, '0);
      check_id("id0", id0, `DD_CL_ID0);
      check_id("id1", id1, `DD_CL_ID1);
      for (int i = 0; i < NCH; i++)
      begin
         check_scrub($sformatf("scrub_req[%0d]", i), scrub_req[i], '0);
         check_flag($sformatf("scrub_done[%0d]", i), scrub_done[i], 1'b0);
      end
      end_test(1, "reset state", err0);

      err0 = errors;
      for (int k = 0; k < 200; k++)
      begin
         r = rand32();
         stat_req_in.wdata = rand32();
         stat_req_in.addr  = r[7:0];
         stat_req_in.wr    = r[8];
         stat_req_in.rd    = r[9] & ~r[8];
         stat_rsp_in.rdata   = rand32();
         stat_rsp_in.int_vec = r[23:16];
         stat_rsp_in.ack     = r[24];
         next_cycle();
      end
      stat_req_in = '0;
      stat_rsp_in = '0;
      repeat (`DD_STAT_STAGES + 1) next_cycle();
      end_test(2, "statistics pipelines", err0);

      err0 = errors;
      for (int k = 0; k < 150; k++)
      begin
         r = rand32();
         // Hold the assert for runs of random length
         if (r[2:0] == 3'd0)
            flr_assert = ~flr_assert;
         next_cycle();
      end
      flr_assert = 1'b0;
      repeat (3) next_cycle();
      end_test(3, "FLR toggle rule", err0);

      err0 = errors;
      ctl0.scrub_en = '1;
      n = 0;
      while (scrub_done != '1 && n < 400)
      begin
         scrub_ready = NCH'(rand32());
         next_cycle();
         n++;
      end
      if (scrub_done != '1)
      begin
         $display("Timeout: scrubbers did not finish the walk");
         errors++;
      end
      repeat (4)
      begin
         scrub_ready = NCH'(rand32());
         next_cycle();
      end
      for (int i = 0; i < NCH; i++)
         check_id($sformatf("accepted bursts ch%0d", i), 32'(acc_cnt[i]), 32'd8);
      end_test(4, "scrub walk under back-pressure", err0);

      err0 = errors;
      ctl0        = '0;
      scrub_ready = '0;
      repeat (3) next_cycle();
      ctl0.scrub_en = '1;
      ctl0.dbg_en   = 1'b1;
      for (int code = 0; code < 8; code++)
      begin
         ctl0.dbg_sel = 3'(code);
         repeat (4)
         begin
            // Sparse ready keeps the channels mid-walk at different addresses
            scrub_ready = NCH'(rand32() & rand32() & rand32());
            next_cycle();
         end
      end
      ctl0.dbg_en = 1'b0;
      repeat (2) next_cycle();
      check_id("id0", id0, `DD_CL_ID0);
      check_id("id1", id1, `DD_CL_ID1);
      end_test(5, "identity selection", err0);

      err0 = errors;
      // Let every channel finish so that each clear also drops a raised done
      n = 0;
      while (scrub_done != '1 && n < 400)
      begin
         scrub_ready = NCH'(rand32());
         next_cycle();
         n++;
      end
      if (scrub_done != '1)
      begin
         $display("Timeout: scrubbers did not finish before the enable clear");
         errors++;
      end
      for (int c = 0; c < NCH; c++)
      begin
         ctl0.scrub_en[c] = 1'b0;
         repeat (2) next_cycle();
         check_flag($sformatf("scrub_done[%0d]", c), scrub_done[c], 1'b0);
         check_scrub($sformatf("scrub_req[%0d]", c), scrub_req[c], '0);
         ctl0.scrub_en[c] = 1'b1;
         repeat (2) next_cycle();
         exp_req.valid = 1'b1;
         exp_req.addr  = '0;
         check_scrub($sformatf("scrub_req[%0d]", c), scrub_req[c], exp_req);
         n = 0;
         while (!scrub_done[c] && n < 100)
         begin
            scrub_ready = NCH'(rand32());
            next_cycle();
            n++;
         end
         if (!scrub_done[c])
         begin
            $display("Timeout: channel %0d did not finish after re-enable", c);
            errors++;
         end
      end
      end_test(6, "enable clear and restart", err0);

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
               errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule
